// File: fft_pkg.sv
`default_nettype none

package fft_pkg;

  // ****************************************
  // transform sizes.
  // ****************************************
  localparam int fft_n         = 16;
  localparam int fft_log2n     = 4;
  localparam int bytes_per_bin = 4;

  typedef logic signed [11:0]          sample_t;
  typedef logic signed [27:0]          data_t;
  typedef logic signed [15:0]          twiddle_t;
  typedef logic        [fft_log2n-1:0] addr_t;
  typedef logic        [1:0]           stage_t;
  typedef logic        [4:0]           shift_t;
  typedef logic        [7:0]           byte_t;

  // ****************************************
  // state machines.
  // ****************************************
  typedef enum logic [2:0] {
    eg_idle,
    eg_load,
    eg_read,
    eg_calc,
    eg_write,
    eg_hold,
    eg_finish
  } engine_state_t;

  typedef enum logic [2:0] {
    ul_idle,
    ul_take_data,
    ul_write,
    ul_read,
    ul_wait,
    ul_count,
    ul_invert,
    ul_done
  } unload_state_t;

endpackage

`default_nettype wire

// File: fft_twiddle_rom.sv
`timescale 1ns/1ps
`default_nettype none

module fft_twiddle_rom (
  input  wire              clk,
  input  wire  [2:0]       idx_i,
  output fft_pkg::twiddle_t w_re_o,
  output fft_pkg::twiddle_t w_im_o
);
  import fft_pkg::*;

  // cos(2*pi*k/16) in q1.14.
  localparam twiddle_t cos_tab [8] = '{
    16'sd16384,
    16'sd15137,
    16'sd11585,
    16'sd6270,
    16'sd0,
    -16'sd6270,
    -16'sd11585,
    -16'sd15137
  };

  // -sin(2*pi*k/16) in q1.14.
  localparam twiddle_t sin_tab [8] = '{
    16'sd0,
    -16'sd6270,
    -16'sd11585,
    -16'sd15137,
    -16'sd16384,
    -16'sd15137,
    -16'sd11585,
    -16'sd6270
  };

  // one cycle from index to factor.
  always_ff @(posedge clk) begin
    w_re_o <= cos_tab[idx_i];
    w_im_o <= sin_tab[idx_i];
  end

endmodule

`default_nettype wire

// File: fft_butterfly.sv
`timescale 1ns/1ps
`default_nettype none

module fft_butterfly (
  input  wire                clk,
  input  wire                rst_n,
  input  wire                en_i,
  input  wire fft_pkg::data_t    a_re_i,
  input  wire fft_pkg::data_t    a_im_i,
  input  wire fft_pkg::data_t    b_re_i,
  input  wire fft_pkg::data_t    b_im_i,
  input  wire fft_pkg::twiddle_t w_re_i,
  input  wire fft_pkg::twiddle_t w_im_i,
  output fft_pkg::data_t         x_re_o,
  output fft_pkg::data_t         x_im_o,
  output fft_pkg::data_t         y_re_o,
  output fft_pkg::data_t         y_im_o
);
  import fft_pkg::*;

  localparam int diff_w    = $bits(data_t) + 1;
  localparam int prod_w    = diff_w + $bits(twiddle_t) + 1;
  localparam int frac_bits = 14;

  logic signed [diff_w-1:0] d_re;
  logic signed [diff_w-1:0] d_im;
  logic signed [prod_w-1:0] p_re;
  logic signed [prod_w-1:0] p_im;

  // difference kept one bit wider so the multiply sees it whole.
  assign d_re = a_re_i - b_re_i;
  assign d_im = a_im_i - b_im_i;

  // complex multiply at full width.
  assign p_re = d_re * w_re_i - d_im * w_im_i;
  assign p_im = d_re * w_im_i + d_im * w_re_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      x_re_o <= '0;
      x_im_o <= '0;
      y_re_o <= '0;
      y_im_o <= '0;
    end else if (en_i) begin
      x_re_o <= a_re_i + b_re_i;
      x_im_o <= a_im_i + b_im_i;
      // truncation by arithmetic shift.
      y_re_o <= data_t'(p_re >>> frac_bits);
      y_im_o <= data_t'(p_im >>> frac_bits);
    end
  end

endmodule

`default_nettype wire

// File: fft_engine.sv
`timescale 1ns/1ps
`default_nettype none

module fft_engine (
  input  wire                   clk,
  input  wire                   rst_n,
  input  wire                   start_i,
  input  wire                   sample_valid_i,
  input  wire fft_pkg::sample_t sample_re_i,
  input  wire fft_pkg::sample_t sample_im_i,
  output logic                  frame_start_o,
  output logic                  back_wr_o,
  output fft_pkg::addr_t        adr1_o,
  output fft_pkg::addr_t        adr2_o,
  output fft_pkg::data_t        re1_o,
  output fft_pkg::data_t        im1_o,
  output fft_pkg::data_t        re2_o,
  output fft_pkg::data_t        im2_o,
  output logic                  finish_o
);
  import fft_pkg::*;

  engine_state_t state;
  data_t         work_re [fft_n];
  data_t         work_im [fft_n];
  addr_t         ld_cnt;
  stage_t        stage;
  logic [2:0]    bf_cnt;
  logic          hold_cnt;
  addr_t         span;
  addr_t         pos_mask;
  addr_t         bf_ext;
  addr_t         lower;
  addr_t         upper;
  logic [2:0]    tw_idx;
  addr_t         adr1_q;
  addr_t         adr2_q;
  data_t         a_re_q, a_im_q, b_re_q, b_im_q;
  twiddle_t      w_re, w_im;
  data_t         x_re, x_im, y_re, y_im;
  logic          last_stage;
  logic          last_bf;
  logic          ld_we;
  logic          bf_we;

  // ****************************************
  // butterfly addressing.
  // ****************************************
  assign span     = addr_t'(8) >> stage;
  assign pos_mask = span - addr_t'(1);
  assign bf_ext   = {1'b0, bf_cnt};
  assign lower    = ((bf_ext & ~pos_mask) << 1) | (bf_ext & pos_mask);
  assign upper    = lower + span;
  assign tw_idx   = (bf_cnt & pos_mask[2:0]) << stage;

  assign last_stage = (stage == stage_t'(fft_log2n - 1));
  assign last_bf    = (bf_cnt == 3'd7);
  assign ld_we      = (state == eg_load) && sample_valid_i;
  assign bf_we      = (state == eg_write) && !last_stage;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state         <= eg_idle;
      ld_cnt        <= '0;
      stage         <= '0;
      bf_cnt        <= '0;
      hold_cnt      <= 1'b0;
      frame_start_o <= 1'b0;
    end else begin
      frame_start_o <= (state == eg_idle) && start_i;
      case (state)
        eg_idle: begin
          if (start_i) begin
            ld_cnt <= '0;
            state  <= eg_load;
          end
        end
        eg_load: begin
          if (sample_valid_i) begin
            ld_cnt <= ld_cnt + addr_t'(1);
            if (ld_cnt == addr_t'(fft_n - 1)) begin
              stage  <= '0;
              bf_cnt <= '0;
              state  <= eg_read;
            end
          end
        end
        eg_read:  state <= eg_calc;
        eg_calc:  state <= eg_write;
        eg_write: begin
          bf_cnt <= bf_cnt + 3'd1;
          if (last_bf) begin
            stage <= stage + stage_t'(1);
          end
          if (last_bf && last_stage) begin
            hold_cnt <= 1'b0;
            state    <= eg_hold;
          end else begin
            state <= eg_read;
          end
        end
        // unloader needs two cycles for the last pair.
        eg_hold: begin
          hold_cnt <= 1'b1;
          if (hold_cnt) begin
            state <= eg_finish;
          end
        end
        eg_finish: state <= eg_idle;
        default:   state <= eg_idle;
      endcase
    end
  end

  // ****************************************
  // working memory.
  // ****************************************
  always_ff @(posedge clk) begin
    if (ld_we) begin
      work_re[ld_cnt] <= data_t'(sample_re_i);
      work_im[ld_cnt] <= data_t'(sample_im_i);
    end
    if (state == eg_read) begin
      a_re_q <= work_re[lower];
      a_im_q <= work_im[lower];
      b_re_q <= work_re[upper];
      b_im_q <= work_im[upper];
    end
    // addresses stay until the next calc.
    if (state == eg_calc) begin
      adr1_q <= lower;
      adr2_q <= upper;
    end
    if (bf_we) begin
      work_re[adr1_q] <= x_re;
      work_im[adr1_q] <= x_im;
      work_re[adr2_q] <= y_re;
      work_im[adr2_q] <= y_im;
    end
  end

  fft_twiddle_rom i_twiddle_rom (
    .clk    (clk),
    .idx_i  (tw_idx),
    .w_re_o (w_re),
    .w_im_o (w_im)
  );

  fft_butterfly i_butterfly (
    .clk    (clk),
    .rst_n  (rst_n),
    .en_i   (state == eg_calc),
    .a_re_i (a_re_q),
    .a_im_i (a_im_q),
    .b_re_i (b_re_q),
    .b_im_i (b_im_q),
    .w_re_i (w_re),
    .w_im_i (w_im),
    .x_re_o (x_re),
    .x_im_o (x_im),
    .y_re_o (y_re),
    .y_im_o (y_im)
  );

  assign back_wr_o = (state == eg_write) && last_stage;
  assign finish_o  = (state == eg_finish);
  assign adr1_o    = adr1_q;
  assign adr2_o    = adr2_q;
  assign re1_o     = x_re;
  assign im1_o     = x_im;
  assign re2_o     = y_re;
  assign im2_o     = y_im;

  // unloader writes a pair over the two cycles after each pulse.
  a_back_wr_spacing: assert property (@(posedge clk) disable iff (!rst_n)
    back_wr_o |=> !back_wr_o ##1 !back_wr_o);

  // strobes outside load leave the load pointer alone.
  a_sample_ignored: assert property (@(posedge clk) disable iff (!rst_n)
    (sample_valid_i && (state != eg_load)) |=> $stable(ld_cnt));

endmodule

`default_nettype wire

// File: fft_output_unloader.sv
`timescale 1ns/1ps
`default_nettype none

module fft_output_unloader (
  input  wire                 clk,
  input  wire                 rst_n,
  input  wire                 back_wr_i,
  input  wire fft_pkg::addr_t adr1_i,
  input  wire fft_pkg::addr_t adr2_i,
  input  wire fft_pkg::data_t re1_i,
  input  wire fft_pkg::data_t im1_i,
  input  wire fft_pkg::data_t re2_i,
  input  wire fft_pkg::data_t im2_i,
  input  wire                 finish_i,
  input  wire                 ready_i,
  input  wire fft_pkg::shift_t win_shift_i,
  output fft_pkg::byte_t      byte_o,
  output logic                byte_valid_o,
  output logic                done_o
);
  import fft_pkg::*;

  unload_state_t      state;
  unload_state_t      state_nxt;
  data_t              res_re [fft_n];
  data_t              res_im [fft_n];
  logic               en_wr;
  logic               en_wr_d;
  logic               mem_we;
  addr_t              wr_ptr1;
  addr_t              wr_ptr2;
  addr_t              wr_adr;
  data_t              wr_re;
  data_t              wr_im;
  logic [fft_log2n:0] rd_cnt;
  addr_t              rd_adr;
  logic [2:0]         byte_idx;
  data_t              bin_re;
  data_t              bin_im;
  data_t              re_sh;
  data_t              im_sh;
  byte_t              byte_buf [bytes_per_bin];

  function automatic addr_t bit_rev(input addr_t a);
    addr_t r;
    for (int i = 0; i < fft_log2n; i++) begin
      r[i] = a[fft_log2n-1-i];
    end
    return r;
  endfunction

  // ****************************************
  // result capture, two writes per pulse.
  // ****************************************
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      en_wr   <= 1'b0;
      en_wr_d <= 1'b0;
    end else begin
      en_wr   <= back_wr_i && !en_wr;
      en_wr_d <= en_wr;
    end
  end

  always_ff @(posedge clk) begin
    if (back_wr_i && !en_wr) begin
      wr_ptr1 <= adr1_i;
    end
    if (en_wr) begin
      wr_ptr2 <= adr2_i;
    end
  end

  // first pair member, then the second.
  assign wr_adr = en_wr ? wr_ptr1 : wr_ptr2;
  assign wr_re  = en_wr ? re1_i : re2_i;
  assign wr_im  = en_wr ? im1_i : im2_i;
  assign mem_we = en_wr || en_wr_d;

  always_ff @(posedge clk) begin
    if (mem_we) begin
      res_re[wr_adr] <= wr_re;
      res_im[wr_adr] <= wr_im;
    end
  end

  // ****************************************
  // readout in bit-reversed order.
  // ****************************************
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= ul_idle;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      ul_idle: begin
        if (finish_i) begin
          state_nxt = ul_take_data;
        end
      end
      ul_take_data: begin
        if (rd_cnt == (fft_log2n + 1)'(fft_n)) begin
          state_nxt = ul_done;
        end else begin
          state_nxt = ul_write;
        end
      end
      ul_write: state_nxt = ul_read;
      ul_read:  state_nxt = ul_wait;
      ul_wait: begin
        if (ready_i) begin
          if (byte_idx == 3'(bytes_per_bin)) begin
            state_nxt = ul_count;
          end else begin
            state_nxt = ul_read;
          end
        end
      end
      ul_count:  state_nxt = ul_invert;
      ul_invert: state_nxt = ul_take_data;
      ul_done:   state_nxt = ul_idle;
      default:   state_nxt = ul_idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_cnt       <= '0;
      rd_adr       <= '0;
      byte_idx     <= '0;
      byte_valid_o <= 1'b0;
      done_o       <= 1'b0;
    end else begin
      byte_valid_o <= (state == ul_read);
      done_o       <= (state == ul_done);
      case (state)
        ul_idle: begin
          rd_cnt   <= '0;
          rd_adr   <= '0;
          byte_idx <= '0;
        end
        ul_read: byte_idx <= byte_idx + 3'd1;
        ul_count: begin
          rd_cnt   <= rd_cnt + 1'b1;
          byte_idx <= '0;
        end
        ul_invert: rd_adr <= bit_rev(rd_cnt[fft_log2n-1:0]);
        default: begin
        end
      endcase
    end
  end

  // byte windows at the configured offset.
  assign re_sh = bin_re >>> win_shift_i;
  assign im_sh = bin_im >>> win_shift_i;

  always_ff @(posedge clk) begin
    if (state == ul_take_data) begin
      bin_re <= res_re[rd_adr];
      bin_im <= res_im[rd_adr];
    end
    if (state == ul_write) begin
      byte_buf[0] <= re_sh[7:0];
      byte_buf[1] <= im_sh[7:0];
      byte_buf[2] <= re_sh[15:8];
      byte_buf[3] <= im_sh[15:8];
    end
    if (state == ul_read) begin
      byte_o <= byte_buf[byte_idx[1:0]];
    end
  end

  // a new frame only arrives once the last one is out.
  a_finish_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
    finish_i |-> (state == ul_idle));

endmodule

`default_nettype wire

// File: fft_cfg_regs.sv
`timescale 1ns/1ps
`default_nettype none

module fft_cfg_regs (
  input  wire                  clk,
  input  wire                  rst_n,
  input  wire                  cfg_we_i,
  input  wire fft_pkg::shift_t cfg_wdata_i,
  output fft_pkg::shift_t      cfg_rdata_o,
  input  wire                  frame_start_i,
  input  wire                  frame_done_i,
  output fft_pkg::shift_t      win_shift_o
);
  import fft_pkg::*;

  localparam shift_t shift_rst = 5'd6;
  localparam shift_t shift_max = 5'd12;

  shift_t shift_q;
  logic   lock_q;

  // locked from frame start until the last byte.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lock_q <= 1'b0;
    end else if (frame_start_i) begin
      lock_q <= 1'b1;
    end else if (frame_done_i) begin
      lock_q <= 1'b0;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      shift_q <= shift_rst;
    end else if (cfg_we_i && !lock_q && !frame_start_i) begin
      shift_q <= (cfg_wdata_i > shift_max) ? shift_max : cfg_wdata_i;
    end
  end

  assign cfg_rdata_o = shift_q;
  assign win_shift_o = shift_q;

endmodule

`default_nettype wire

// File: fft_top.sv
`timescale 1ns/1ps
`default_nettype none

module fft_top (
  input  wire                   clk,
  input  wire                   rst_n,
  input  wire                   start_i,
  input  wire                   sample_valid_i,
  input  wire fft_pkg::sample_t sample_re_i,
  input  wire fft_pkg::sample_t sample_im_i,
  input  wire                   ready_i,
  input  wire                   cfg_we_i,
  input  wire fft_pkg::shift_t  cfg_wdata_i,
  output fft_pkg::shift_t       cfg_rdata_o,
  output fft_pkg::byte_t        byte_o,
  output logic                  byte_valid_o,
  output logic                  done_o
);
  import fft_pkg::*;

  logic   frame_start;
  logic   back_wr;
  logic   finish;
  addr_t  adr1, adr2;
  data_t  re1, im1, re2, im2;
  shift_t win_shift;

  fft_engine i_engine (
    .clk            (clk),
    .rst_n          (rst_n),
    .start_i        (start_i),
    .sample_valid_i (sample_valid_i),
    .sample_re_i    (sample_re_i),
    .sample_im_i    (sample_im_i),
    .frame_start_o  (frame_start),
    .back_wr_o      (back_wr),
    .adr1_o         (adr1),
    .adr2_o         (adr2),
    .re1_o          (re1),
    .im1_o          (im1),
    .re2_o          (re2),
    .im2_o          (im2),
    .finish_o       (finish)
  );

  fft_output_unloader i_unloader (
    .clk          (clk),
    .rst_n        (rst_n),
    .back_wr_i    (back_wr),
    .adr1_i       (adr1),
    .adr2_i       (adr2),
    .re1_i        (re1),
    .im1_i        (im1),
    .re2_i        (re2),
    .im2_i        (im2),
    .finish_i     (finish),
    .ready_i      (ready_i),
    .win_shift_i  (win_shift),
    .byte_o       (byte_o),
    .byte_valid_o (byte_valid_o),
    .done_o       (done_o)
  );

  fft_cfg_regs i_cfg_regs (
    .clk           (clk),
    .rst_n         (rst_n),
    .cfg_we_i      (cfg_we_i),
    .cfg_wdata_i   (cfg_wdata_i),
    .cfg_rdata_o   (cfg_rdata_o),
    .frame_start_i (frame_start),
    .frame_done_i  (done_o),
    .win_shift_o   (win_shift)
  );

endmodule

`default_nettype wire

// File: tb_fft_ref.svh
`ifndef TB_FFT_REF_SVH
`define TB_FFT_REF_SVH
`default_nettype none

// ****************************************
// fixed-point reference model.
// ****************************************

// results in natural bin order.
longint ref_re [16];
longint ref_im [16];

function automatic longint tw_cos(input int k);
  case (k)
    0: return 16384;
    1: return 15137;
    2: return 11585;
    3: return 6270;
    4: return 0;
    5: return -6270;
    6: return -11585;
    default: return -15137;
  endcase
endfunction

function automatic longint tw_sin(input int k);
  case (k)
    0: return 0;
    1: return -6270;
    2: return -11585;
    3: return -15137;
    4: return -16384;
    5: return -15137;
    6: return -11585;
    default: return -6270;
  endcase
endfunction

// keeps the low 28 bits as a signed value.
function automatic longint wrap28(input longint v);
  logic signed [27:0] t;
  t = v[27:0];
  return longint'(t);
endfunction

function automatic int rev4(input int k);
  return ((k & 1) << 3) | ((k & 2) << 1) | ((k & 4) >> 1) | ((k & 8) >> 3);
endfunction

function automatic void model_fft(input longint in_re [16], input longint in_im [16]);
  longint w_re [16];
  longint w_im [16];
  longint dre, dim, pre, pim, wr, wi;
  int     i, s, b, span, pos, lo, hi, k;
  for (i = 0; i < 16; i++) begin
    w_re[i] = in_re[i];
    w_im[i] = in_im[i];
  end
  for (s = 0; s < 4; s++) begin
    span = 8 >> s;
    for (b = 0; b < 8; b++) begin
      // group start plus position in the group.
      pos = b % span;
      lo  = (b / span) * 2 * span + pos;
      hi  = lo + span;
      k   = pos << s;
      wr  = tw_cos(k);
      wi  = tw_sin(k);
      dre = w_re[lo] - w_re[hi];
      dim = w_im[lo] - w_im[hi];
      w_re[lo] = wrap28(w_re[lo] + w_re[hi]);
      w_im[lo] = wrap28(w_im[lo] + w_im[hi]);
      pre = dre * wr - dim * wi;
      pim = dre * wi + dim * wr;
      w_re[hi] = wrap28(pre >>> 14);
      w_im[hi] = wrap28(pim >>> 14);
    end
  end
  // dif leaves the bins in bit-reversed order.
  for (i = 0; i < 16; i++) begin
    ref_re[i] = w_re[rev4(i)];
    ref_im[i] = w_im[rev4(i)];
  end
endfunction

// slots: re low, im low, re high, im high.
function automatic byte_t model_byte(input int bin, input int slot, input int shift);
  longint v;
  int     pos;
  v   = (slot % 2 == 0) ? ref_re[bin] : ref_im[bin];
  pos = (slot < 2) ? shift : shift + 8;
  return byte_t'((v >>> pos) & 255);
endfunction

`default_nettype wire
`endif

// File: tb_fft_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fft_top;
  import fft_pkg::*;

  localparam int clk_half    = 50;
  localparam int rst_cycles  = 10;
  localparam int frame_limit = 5000;

  logic    clk;
  logic    rst_n;
  logic    start_i;
  logic    sample_valid_i;
  sample_t sample_re_i;
  sample_t sample_im_i;
  logic    ready_i;
  logic    cfg_we_i;
  shift_t  cfg_wdata_i;
  shift_t  cfg_rdata_o;
  byte_t   byte_o;
  logic    byte_valid_o;
  logic    done_o;

  integer  seed;
  logic    ready_random;
  int      shift_exp;
  int      byte_cnt;
  int      done_cnt;
  byte_t   exp_bytes [$];
  longint  smp_re [16];
  longint  smp_im [16];

  `include "tb_fft_ref.svh"

  fft_top i_dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .start_i        (start_i),
    .sample_valid_i (sample_valid_i),
    .sample_re_i    (sample_re_i),
    .sample_im_i    (sample_im_i),
    .ready_i        (ready_i),
    .cfg_we_i       (cfg_we_i),
    .cfg_wdata_i    (cfg_wdata_i),
    .cfg_rdata_o    (cfg_rdata_o),
    .byte_o         (byte_o),
    .byte_valid_o   (byte_valid_o),
    .done_o         (done_o)
  );

  always #(clk_half) clk = ~clk;

  task automatic stop_with_failure(input string what);
    $display("%s", what);
    $display("SOME TESTS FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_byte(input string name, input byte_t got, input byte_t exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("error %s: got %02h, expected %02h", name, got, exp));
    end
  endtask

  task automatic check_shift(input string name, input shift_t got, input shift_t exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("error %s: got %02h, expected %02h", name, got, exp));
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      stop_with_failure($sformatf("error %s: got %0h, expected %0h", name, got, exp));
    end
  endtask

  function automatic int rand_below(input int n);
    int r;
    r = $random(seed);
    return int'(r[15:0]) % n;
  endfunction

  // inputs change just after the rising edge.
  task automatic next_cycle();
    @(posedge clk);
    #1;
    ready_i = ready_random ? (rand_below(2) == 1) : 1'b1;
  endtask

  task automatic write_cfg(input int value);
    cfg_we_i    = 1'b1;
    cfg_wdata_i = shift_t'(value);
    next_cycle();
    cfg_we_i    = 1'b0;
  endtask

  task automatic set_offset(input int value);
    write_cfg(value);
    shift_exp = (value > 12) ? 12 : value;
    check_shift("cfg_rdata_o", cfg_rdata_o, shift_t'(shift_exp));
  endtask

  task automatic fill_random();
    for (int i = 0; i < fft_n; i++) begin
      smp_re[i] = rand_below(4096) - 2048;
      smp_im[i] = rand_below(4096) - 2048;
    end
  endtask

  task automatic wait_frame_done(input int done_base);
    int cycles;
    cycles = 0;
    while (done_cnt == done_base) begin
      next_cycle();
      cycles++;
      if (cycles > frame_limit) begin
        stop_with_failure("timeout while waiting for done_o at the end of a frame");
      end
    end
  endtask

  // ****************************************
  // one frame: load, then collect bytes.
  // ****************************************
  task automatic run_frame(input int start_mid, input int cfg_mid);
    int byte_base;
    int done_base;
    int bin;
    int slot;
    model_fft(smp_re, smp_im);
    for (bin = 0; bin < fft_n; bin++) begin
      for (slot = 0; slot < bytes_per_bin; slot++) begin
        exp_bytes.push_back(model_byte(bin, slot, shift_exp));
      end
    end
    byte_base = byte_cnt;
    done_base = done_cnt;
    start_i = 1'b1;
    next_cycle();
    start_i = 1'b0;
    for (int i = 0; i < fft_n; i++) begin
      repeat (rand_below(3)) next_cycle();
      if (i == 6 && start_mid != 0) begin
        start_i = 1'b1;
        next_cycle();
        start_i = 1'b0;
      end
      // locked, so the offset must not move.
      if (i == 8 && cfg_mid >= 0) begin
        write_cfg(cfg_mid);
        check_shift("cfg_rdata_o", cfg_rdata_o, shift_t'(shift_exp));
      end
      sample_valid_i = 1'b1;
      sample_re_i    = sample_t'(smp_re[i]);
      sample_im_i    = sample_t'(smp_im[i]);
      next_cycle();
      sample_valid_i = 1'b0;
    end
    if (start_mid != 0) begin
      repeat (10) next_cycle();
      start_i = 1'b1;
      next_cycle();
      start_i = 1'b0;
    end
    wait_frame_done(done_base);
    repeat (4) next_cycle();
    check_count("byte_valid_o strobes", byte_cnt - byte_base, fft_n * bytes_per_bin);
    check_count("done_o pulses", done_cnt - done_base, 1);
  endtask

  // compare process.
  always @(negedge clk) begin
    if (byte_valid_o === 1'b1) begin
      byte_cnt++;
      if (exp_bytes.size() == 0) begin
        stop_with_failure("byte_valid_o strobe arrived while no byte was expected");
      end else begin
        check_byte("byte_o", byte_o, exp_bytes.pop_front());
      end
    end
    if (done_o === 1'b1) begin
      done_cnt++;
    end
  end

  initial begin
    int offsets [3];
    clk            = 1'b0;
    rst_n          = 1'b0;
    start_i        = 1'b0;
    sample_valid_i = 1'b0;
    sample_re_i    = '0;
    sample_im_i    = '0;
    ready_i        = 1'b1;
    cfg_we_i       = 1'b0;
    cfg_wdata_i    = '0;
    seed           = 32'h887b_870d;
    ready_random   = 1'b0;
    shift_exp      = 6;
    byte_cnt       = 0;
    done_cnt       = 0;
    offsets        = '{0, 12, 20};
    repeat (rst_cycles) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // quiet after reset, then an impulse.
    repeat (5) next_cycle();
    check_count("byte_valid_o strobes after reset", byte_cnt, 0);
    check_count("done_o pulses after reset", done_cnt, 0);
    check_shift("cfg_rdata_o", cfg_rdata_o, 5'd6);
    for (int i = 0; i < fft_n; i++) begin
      smp_re[i] = 0;
      smp_im[i] = 0;
    end
    smp_re[0] = 1000;
    run_frame(0, -1);

    for (int f = 0; f < 10; f++) begin
      fill_random();
      run_frame(0, -1);
    end

    // consumer stalls.
    ready_random = 1'b1;
    for (int f = 0; f < 6; f++) begin
      fill_random();
      run_frame(0, -1);
    end
    ready_random = 1'b0;

    for (int j = 0; j < 3; j++) begin
      set_offset(offsets[j]);
      fill_random();
      run_frame(0, -1);
    end
    set_offset(3);
    fill_random();
    run_frame(0, 9);

    // stray start strobes.
    ready_random = 1'b1;
    fill_random();
    run_frame(1, -1);

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
+incdir+.
fft_pkg.sv
fft_twiddle_rom.sv
fft_butterfly.sv
fft_engine.sv
fft_output_unloader.sv
fft_cfg_regs.sv
fft_top.sv
tb_fft_top.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_fft_top -f project.f -o sim_fft
status=0
./obj_dir/sim_fft > sim.log 2>&1 || status=$?
cat sim.log
if grep -q "SOME TESTS FAILED" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi
exit "$status"
